// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int lq_size = 8;
    localparam int ways = 2;
    localparam int rob_size = 32;
    localparam int prf_size = 64;

    typedef logic [$clog2(lq_size)-1:0] lq_idx_t;
    typedef logic [$clog2(lq_size):0] lq_count_t;
    typedef logic [$clog2(rob_size)-1:0] rob_idx_t;
    typedef logic [$clog2(prf_size)-1:0] prf_idx_t;

    // size is coded as mem_pkg::mem_size_t
    typedef struct packed {
        logic enable;
        logic [1:0] size;
        logic is_signed;
        rob_idx_t rob_idx;
        prf_idx_t prf_idx;
        lq_idx_t sq_tail;
    } ld_dispatch_t;

    typedef struct packed {
        logic valid;
        logic is_ls;
        rob_idx_t rob_idx;
        logic [15:0] addr;
    } alu_result_t;

    typedef struct packed {
        logic valid;
        logic addr_valid;
        logic data_valid;
        logic [1:0] size;
        logic [15:0] addr;
        logic [31:0] data;
    } store_entry_t;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
        prf_idx_t prf_idx;
        rob_idx_t rob_idx;
    } cdb_t;

    typedef enum logic [1:0] {
        wait_addr,
        ready_cache,
        wait_mem,
        done
    } ld_state_t;

endpackage

`default_nettype wire

// File: design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    typedef enum logic [1:0] {
        mem_byte = 2'd0,
        mem_half = 2'd1,
        mem_word = 2'd2
    } mem_size_t;

    // store compare view
    typedef struct packed {
        logic [12:0] block;
        logic [2:0] offset;
    } blk_view_t;

    // dcache lookup view
    typedef struct packed {
        logic [7:0] tag;
        logic [4:0] index;
        logic [2:0] offset;
    } cache_view_t;

    typedef union packed {
        blk_view_t blk;
        cache_view_t cache;
    } mem_addr_u;

    typedef struct packed {
        logic enable;
        mem_addr_u addr;
        mem_size_t size;
        core_pkg::lq_idx_t lq_idx;
    } cache_req_t;

    typedef struct packed {
        logic valid;
        core_pkg::lq_idx_t lq_idx;
        logic [31:0] data;
    } mem_fill_t;

endpackage

`default_nettype wire

// File: design/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int width = core_pkg::lq_size
) (
    input  logic clock,
    input  logic reset,
    input  logic [width-1:0] req,
    output logic [width-1:0] gnt
);

    // bits at or above the priority pointer
    logic [width-1:0] mask;
    logic [width-1:0] masked;
    logic [width-1:0] pick;

    assign masked = req & mask;
    assign pick = (|masked) ? masked : req;
    // lowest set bit
    assign gnt = pick & (~pick + 1'b1);

    always_ff @(posedge clock) begin
        if (reset) begin
            mask <= '1;
        end else if (|gnt) begin
            // everything strictly above the winner, empty wraps to all
            mask <= ~((gnt << 1) - 1'b1);
        end
    end

endmodule

`default_nettype wire

// File: design/lq_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module lq_alloc (
    input  logic [core_pkg::lq_size-1:0] free,
    input  core_pkg::ld_dispatch_t dispatch [core_pkg::ways],
    output logic [core_pkg::lq_size-1:0] alloc,
    output core_pkg::ld_dispatch_t alloc_data [core_pkg::lq_size]
);

    logic [core_pkg::lq_size-1:0] pick0;
    logic [core_pkg::lq_size-1:0] pick1;

    always_comb begin
        pick0 = '0;
        pick1 = '0;
        // way 0 ends on the lowest free entry
        for (int i = core_pkg::lq_size - 1; i >= 0; i--) begin
            if (free[i] && dispatch[0].enable) begin
                pick0 = '0;
                pick0[i] = 1'b1;
            end
        end
        // way 1 ends on the highest one left
        for (int i = 0; i < core_pkg::lq_size; i++) begin
            if (free[i] && !pick0[i] && dispatch[1].enable) begin
                pick1 = '0;
                pick1[i] = 1'b1;
            end
        end
    end

    assign alloc = pick0 | pick1;

    // only meaningful where alloc is set
    always_comb begin
        for (int i = 0; i < core_pkg::lq_size; i++) begin
            alloc_data[i] = pick1[i] ? dispatch[1] : dispatch[0];
        end
    end

endmodule

`default_nettype wire

// File: design/lq_store_check.sv
`timescale 1ns/1ps
`default_nettype none

module lq_store_check (
    input  logic [core_pkg::lq_size-1:0] occupied,
    input  logic [core_pkg::lq_size-1:0] addr_ready,
    input  mem_pkg::mem_addr_u ld_addr [core_pkg::lq_size],
    input  mem_pkg::mem_size_t ld_size [core_pkg::lq_size],
    input  core_pkg::lq_idx_t sq_tail [core_pkg::lq_size],
    input  core_pkg::store_entry_t stores [core_pkg::lq_size],
    input  core_pkg::lq_idx_t sq_head,
    output logic [core_pkg::lq_size-1:0] can_forward,
    output logic [core_pkg::lq_size-1:0] blocked,
    output logic [31:0] fwd_data [core_pkg::lq_size]
);

    always_comb begin
        logic [core_pkg::lq_size-1:0] conflict;
        logic wrap;
        logic older;
        logic found;
        logic match;
        core_pkg::lq_idx_t k;
        core_pkg::lq_idx_t sel;
        mem_pkg::mem_addr_u st_addr;

        for (int i = 0; i < core_pkg::lq_size; i++) begin
            // older stores sit from head up to the tail snapshot
            wrap = sq_head > sq_tail[i];
            for (int j = 0; j < core_pkg::lq_size; j++) begin
                if (wrap) begin
                    older = (j >= sq_head) || (j < sq_tail[i]);
                end else begin
                    older = (j >= sq_head) && (j < sq_tail[i]);
                end
                st_addr = stores[j].addr;
                conflict[j] = older && stores[j].valid &&
                    (!stores[j].addr_valid || st_addr.blk.block == ld_addr[i].blk.block);
            end

            // walk back from the tail, first hit is the youngest
            found = 1'b0;
            sel = sq_tail[i];
            for (int n = 1; n <= core_pkg::lq_size; n++) begin
                k = sq_tail[i] - core_pkg::lq_idx_t'(n);
                if (!found && conflict[k]) begin
                    found = 1'b1;
                    sel = k;
                end
            end

            st_addr = stores[sel].addr;
            match = stores[sel].addr_valid && stores[sel].data_valid &&
                st_addr.blk.offset == ld_addr[i].blk.offset &&
                stores[sel].size == ld_size[i];
            can_forward[i] = occupied[i] && addr_ready[i] && found && match;
            blocked[i] = occupied[i] && addr_ready[i] && found && !match;
            fwd_data[i] = stores[sel].data;
        end
    end

endmodule

`default_nettype wire

// File: design/lq_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module lq_entry_array (
    input  logic clock,
    input  logic reset,
    input  logic except,
    input  logic [core_pkg::lq_size-1:0] alloc,
    input  core_pkg::ld_dispatch_t alloc_data [core_pkg::lq_size],
    input  core_pkg::alu_result_t alu [core_pkg::ways],
    input  logic [core_pkg::lq_size-1:0] can_forward,
    input  logic [core_pkg::lq_size-1:0] blocked,
    input  logic [31:0] fwd_data [core_pkg::lq_size],
    input  logic [core_pkg::lq_size-1:0] cache_gnt,
    input  logic [core_pkg::lq_size-1:0] cdb_gnt,
    input  logic dc_hit,
    input  logic [31:0] dc_data,
    input  mem_pkg::mem_fill_t fill,
    output logic [core_pkg::lq_size-1:0] occupied,
    output logic [core_pkg::lq_size-1:0] addr_ready,
    output mem_pkg::mem_addr_u ld_addr [core_pkg::lq_size],
    output mem_pkg::mem_size_t ld_size [core_pkg::lq_size],
    output core_pkg::lq_idx_t sq_tail [core_pkg::lq_size],
    output logic [core_pkg::lq_size-1:0] cache_req,
    output logic [core_pkg::lq_size-1:0] done,
    output mem_pkg::cache_req_t rd,
    output logic [31:0] entry_data [core_pkg::lq_size],
    output mem_pkg::mem_size_t entry_size [core_pkg::lq_size],
    output logic [core_pkg::lq_size-1:0] entry_signed,
    output core_pkg::rob_idx_t entry_rob [core_pkg::lq_size],
    output core_pkg::prf_idx_t entry_prf [core_pkg::lq_size],
    output core_pkg::lq_count_t lq_num_free
);

    core_pkg::ld_state_t state [core_pkg::lq_size];
    core_pkg::lq_count_t free_count;
    logic [core_pkg::lq_size-1:0] alu_hit;
    logic [core_pkg::lq_size-1:0] fill_hit;
    logic [15:0] alu_addr [core_pkg::lq_size];

    // address capture and fill match per entry
    always_comb begin
        for (int i = 0; i < core_pkg::lq_size; i++) begin
            alu_hit[i] = 1'b0;
            alu_addr[i] = alu[0].addr;
            for (int w = 0; w < core_pkg::ways; w++) begin
                if (alu[w].valid && alu[w].is_ls && occupied[i] && !addr_ready[i] &&
                        alu[w].rob_idx == entry_rob[i]) begin
                    alu_hit[i] = 1'b1;
                    alu_addr[i] = alu[w].addr;
                end
            end
            fill_hit[i] = fill.valid && fill.lq_idx == core_pkg::lq_idx_t'(i) &&
                state[i] == core_pkg::wait_mem;
            cache_req[i] = state[i] == core_pkg::ready_cache;
            done[i] = state[i] == core_pkg::done;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || except) begin
            for (int i = 0; i < core_pkg::lq_size; i++) begin
                occupied[i] <= 1'b0;
                addr_ready[i] <= 1'b0;
                state[i] <= core_pkg::wait_addr;
            end
            free_count <= core_pkg::lq_count_t'(core_pkg::lq_size);
        end else begin
            for (int i = 0; i < core_pkg::lq_size; i++) begin
                if (alloc[i]) begin
                    occupied[i] <= 1'b1;
                    addr_ready[i] <= 1'b0;
                    state[i] <= core_pkg::wait_addr;
                end else begin
                    if (alu_hit[i]) begin
                        addr_ready[i] <= 1'b1;
                    end
                    case (state[i])
                        core_pkg::wait_addr: begin
                            if (can_forward[i]) begin
                                state[i] <= core_pkg::done;
                            end else if (occupied[i] && addr_ready[i] && !blocked[i]) begin
                                state[i] <= core_pkg::ready_cache;
                            end
                        end
                        core_pkg::ready_cache: begin
                            if (cache_gnt[i]) begin
                                state[i] <= dc_hit ? core_pkg::done : core_pkg::wait_mem;
                            end
                        end
                        core_pkg::wait_mem: begin
                            if (fill_hit[i]) begin
                                state[i] <= core_pkg::done;
                            end
                        end
                        default: begin
                            // broadcast frees the entry
                            if (cdb_gnt[i]) begin
                                state[i] <= core_pkg::wait_addr;
                                occupied[i] <= 1'b0;
                                addr_ready[i] <= 1'b0;
                            end
                        end
                    endcase
                end
            end
            free_count <= free_count - core_pkg::lq_count_t'($countones(alloc)) +
                core_pkg::lq_count_t'(|cdb_gnt);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < core_pkg::lq_size; i++) begin
            if (alloc[i]) begin
                ld_size[i] <= mem_pkg::mem_size_t'(alloc_data[i].size);
                entry_signed[i] <= alloc_data[i].is_signed;
                entry_rob[i] <= alloc_data[i].rob_idx;
                entry_prf[i] <= alloc_data[i].prf_idx;
                sq_tail[i] <= alloc_data[i].sq_tail;
            end
            if (alu_hit[i]) begin
                ld_addr[i] <= alu_addr[i];
            end
            // load data from forward, hit or fill
            if (state[i] == core_pkg::wait_addr && can_forward[i]) begin
                entry_data[i] <= fwd_data[i];
            end else if (state[i] == core_pkg::ready_cache && cache_gnt[i] && dc_hit) begin
                entry_data[i] <= dc_data;
            end else if (fill_hit[i]) begin
                entry_data[i] <= fill.data;
            end
        end
    end

    assign entry_size = ld_size;

    // granted entry drives the dcache read
    always_comb begin
        rd = '0;
        for (int i = 0; i < core_pkg::lq_size; i++) begin
            if (cache_gnt[i]) begin
                rd.enable = 1'b1;
                rd.addr.cache = ld_addr[i].cache;
                rd.size = ld_size[i];
                rd.lq_idx = core_pkg::lq_idx_t'(i);
            end
        end
    end

    // dispatch needs room for both ways
    assign lq_num_free = (free_count < core_pkg::lq_count_t'(core_pkg::ways)) ? '0 : free_count;

endmodule

`default_nettype wire

// File: design/lq_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module lq_writeback (
    input  logic [core_pkg::lq_size-1:0] cdb_gnt,
    input  logic [31:0] entry_data [core_pkg::lq_size],
    input  mem_pkg::mem_size_t entry_size [core_pkg::lq_size],
    input  logic [core_pkg::lq_size-1:0] entry_signed,
    input  core_pkg::rob_idx_t entry_rob [core_pkg::lq_size],
    input  core_pkg::prf_idx_t entry_prf [core_pkg::lq_size],
    output core_pkg::cdb_t cdb
);

    always_comb begin
        logic [31:0] raw;
        mem_pkg::mem_size_t sel_size;
        logic sign;

        raw = '0;
        sel_size = mem_pkg::mem_word;
        sign = 1'b0;
        cdb = '0;
        for (int i = 0; i < core_pkg::lq_size; i++) begin
            if (cdb_gnt[i]) begin
                raw = entry_data[i];
                sel_size = entry_size[i];
                sign = entry_signed[i];
                cdb.rob_idx = entry_rob[i];
                cdb.prf_idx = entry_prf[i];
            end
        end
        cdb.valid = |cdb_gnt;
        // narrow loads arrive right-aligned
        case (sel_size)
            mem_pkg::mem_byte: cdb.data = {{24{sign & raw[7]}}, raw[7:0]};
            mem_pkg::mem_half: cdb.data = {{16{sign & raw[15]}}, raw[15:0]};
            default: cdb.data = raw;
        endcase
    end

endmodule

`default_nettype wire

// File: design/load_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue (
    input  logic clock,
    input  logic reset,
    input  logic except,
    input  core_pkg::ld_dispatch_t dispatch [core_pkg::ways],
    input  core_pkg::alu_result_t alu [core_pkg::ways],
    input  core_pkg::store_entry_t stores [core_pkg::lq_size],
    input  core_pkg::lq_idx_t sq_head,
    input  logic dc_hit,
    input  logic [31:0] dc_data,
    input  mem_pkg::mem_fill_t fill,
    output mem_pkg::cache_req_t rd,
    output core_pkg::cdb_t cdb,
    output core_pkg::lq_count_t lq_num_free
);

    logic [core_pkg::lq_size-1:0] alloc;
    core_pkg::ld_dispatch_t alloc_data [core_pkg::lq_size];

    logic [core_pkg::lq_size-1:0] occupied;
    logic [core_pkg::lq_size-1:0] addr_ready;
    mem_pkg::mem_addr_u ld_addr [core_pkg::lq_size];
    mem_pkg::mem_size_t ld_size [core_pkg::lq_size];
    core_pkg::lq_idx_t sq_tail [core_pkg::lq_size];

    logic [core_pkg::lq_size-1:0] can_forward;
    logic [core_pkg::lq_size-1:0] blocked;
    logic [31:0] fwd_data [core_pkg::lq_size];

    logic [core_pkg::lq_size-1:0] cache_req;
    logic [core_pkg::lq_size-1:0] done;
    logic [core_pkg::lq_size-1:0] cache_gnt;
    logic [core_pkg::lq_size-1:0] cdb_gnt;

    logic [31:0] entry_data [core_pkg::lq_size];
    mem_pkg::mem_size_t entry_size [core_pkg::lq_size];
    logic [core_pkg::lq_size-1:0] entry_signed;
    core_pkg::rob_idx_t entry_rob [core_pkg::lq_size];
    core_pkg::prf_idx_t entry_prf [core_pkg::lq_size];

    lq_alloc alloc_inst (
        .free(~occupied),
        .dispatch(dispatch),
        .alloc(alloc),
        .alloc_data(alloc_data)
    );

    lq_store_check store_check_inst (
        .occupied(occupied),
        .addr_ready(addr_ready),
        .ld_addr(ld_addr),
        .ld_size(ld_size),
        .sq_tail(sq_tail),
        .stores(stores),
        .sq_head(sq_head),
        .can_forward(can_forward),
        .blocked(blocked),
        .fwd_data(fwd_data)
    );

    lq_entry_array entry_array_inst (
        .clock(clock),
        .reset(reset),
        .except(except),
        .alloc(alloc),
        .alloc_data(alloc_data),
        .alu(alu),
        .can_forward(can_forward),
        .blocked(blocked),
        .fwd_data(fwd_data),
        .cache_gnt(cache_gnt),
        .cdb_gnt(cdb_gnt),
        .dc_hit(dc_hit),
        .dc_data(dc_data),
        .fill(fill),
        .occupied(occupied),
        .addr_ready(addr_ready),
        .ld_addr(ld_addr),
        .ld_size(ld_size),
        .sq_tail(sq_tail),
        .cache_req(cache_req),
        .done(done),
        .rd(rd),
        .entry_data(entry_data),
        .entry_size(entry_size),
        .entry_signed(entry_signed),
        .entry_rob(entry_rob),
        .entry_prf(entry_prf),
        .lq_num_free(lq_num_free)
    );

    // one load to the dcache per cycle
    rr_arbiter #(.width(core_pkg::lq_size)) cache_arb (
        .clock(clock),
        .reset(reset),
        .req(cache_req),
        .gnt(cache_gnt)
    );

    // one finished load on the cdb per cycle
    rr_arbiter #(.width(core_pkg::lq_size)) cdb_arb (
        .clock(clock),
        .reset(reset),
        .req(done),
        .gnt(cdb_gnt)
    );

    lq_writeback writeback_inst (
        .cdb_gnt(cdb_gnt),
        .entry_data(entry_data),
        .entry_size(entry_size),
        .entry_signed(entry_signed),
        .entry_rob(entry_rob),
        .entry_prf(entry_prf),
        .cdb(cdb)
    );

endmodule

`default_nettype wire

// File: verification/load_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module load_queue_tb;

    localparam int max_loads = 2;
    localparam int wait_limit = 200;

    typedef struct packed {
        logic [1:0] size;
        logic is_signed;
        core_pkg::rob_idx_t rob;
        core_pkg::prf_idx_t prf;
        core_pkg::lq_idx_t tail;
        logic [15:0] addr;
        logic [1:0] mode;
        logic [31:0] mem_data;
        logic [31:0] exp_data;
    } load_rec_t;

    logic clock;
    logic reset;
    logic except;
    core_pkg::ld_dispatch_t dispatch [core_pkg::ways];
    core_pkg::alu_result_t alu [core_pkg::ways];
    core_pkg::store_entry_t stores [core_pkg::lq_size];
    core_pkg::lq_idx_t sq_head;
    logic dc_hit;
    logic [31:0] dc_data;
    mem_pkg::mem_fill_t fill;
    mem_pkg::cache_req_t rd;
    core_pkg::cdb_t cdb;
    core_pkg::lq_count_t lq_num_free;

    // loads of the test being run
    load_rec_t loads [max_loads];
    core_pkg::lq_idx_t fill_idx [max_loads];
    int fill_cnt [max_loads];
    logic [max_loads-1:0] seen;
    logic [max_loads-1:0] pend;
    int n_loads;
    int kind;
    int blk_slot;
    logic [15:0] late_addr;
    logic reads_barred;
    logic bcast_barred;
    int errors;
    int tests_run;
    int tests_bad;

    load_queue load_queue_inst (
        .clock(clock),
        .reset(reset),
        .except(except),
        .dispatch(dispatch),
        .alu(alu),
        .stores(stores),
        .sq_head(sq_head),
        .dc_hit(dc_hit),
        .dc_data(dc_data),
        .fill(fill),
        .rd(rd),
        .cdb(cdb),
        .lq_num_free(lq_num_free)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic int load_at(input logic [15:0] addr);
        int k;
        k = -1;
        for (int i = 0; i < n_loads; i++) begin
            if (loads[i].addr == addr) begin
                k = i;
            end
        end
        return k;
    endfunction

    function automatic int load_of_rob(input core_pkg::rob_idx_t rob);
        int k;
        k = -1;
        for (int i = 0; i < n_loads; i++) begin
            if (loads[i].rob == rob) begin
                k = i;
            end
        end
        return k;
    endfunction

    // dcache and memory model plus cdb monitor
    task automatic respond();
        int k;
        logic fill_busy;
        logic [15:0] ra;

        fill_busy = 1'b0;
        ra = rd.addr;
        // one fill per cycle, the others slip
        for (int i = 0; i < n_loads; i++) begin
            if (pend[i]) begin
                fill_cnt[i] = fill_cnt[i] - 1;
                if (fill_cnt[i] <= 0 && !fill_busy) begin
                    fill.valid = 1'b1;
                    fill.lq_idx = fill_idx[i];
                    fill.data = loads[i].mem_data;
                    pend[i] = 1'b0;
                    fill_busy = 1'b1;
                end
            end
        end
        if (rd.enable) begin
            k = load_at(ra);
            if (reads_barred) begin
                $display("dcache read of %h while reads must stay idle", ra);
                errors++;
            end else if (k < 0) begin
                $display("dcache read of %h matches no load of this test", ra);
                errors++;
            end else if (loads[k].mode == 2'd2) begin
                $display("forwarded load at %h went to the dcache", ra);
                errors++;
            end else begin
                check("rd.size", 32'(rd.size), 32'(loads[k].size));
                if (loads[k].mode == 2'd1) begin
                    dc_hit = 1'b1;
                    dc_data = loads[k].mem_data;
                end else begin
                    // miss, memory answers 2 to 6 cycles later
                    pend[k] = 1'b1;
                    fill_idx[k] = rd.lq_idx;
                    fill_cnt[k] = 2 + int'($urandom % 5);
                end
            end
        end
        if (cdb.valid) begin
            k = load_of_rob(cdb.rob_idx);
            if (bcast_barred) begin
                $display("cdb broadcast for rob %h while the queue is empty", cdb.rob_idx);
                errors++;
            end else if (k < 0 || seen[k]) begin
                $display("unexpected cdb broadcast for rob %h", cdb.rob_idx);
                errors++;
            end else begin
                seen[k] = 1'b1;
                check("cdb.data", cdb.data, loads[k].exp_data);
                check("cdb.prf_idx", 32'(cdb.prf_idx), 32'(loads[k].prf));
            end
        end
    endtask

    // inputs change on the falling edge, pulses last one cycle
    task automatic next_cycle();
        @(negedge clock);
        except = 1'b0;
        dc_hit = 1'b0;
        fill.valid = 1'b0;
        for (int w = 0; w < core_pkg::ways; w++) begin
            dispatch[w].enable = 1'b0;
            alu[w].valid = 1'b0;
        end
        respond();
    endtask

    task automatic report(input string label, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("%s: ok", label);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", label, errors - start_errors);
        end
    endtask

    task automatic run_test();
        int waited;
        int start_errors;
        logic [max_loads-1:0] want;

        start_errors = errors;
        seen = '0;
        pend = '0;
        want = '0;
        for (int k = 0; k < n_loads; k++) begin
            want[k] = 1'b1;
        end
        next_cycle();
        // load k goes out on way k
        for (int k = 0; k < n_loads; k++) begin
            dispatch[k].enable = 1'b1;
            dispatch[k].size = loads[k].size;
            dispatch[k].is_signed = loads[k].is_signed;
            dispatch[k].rob_idx = loads[k].rob;
            dispatch[k].prf_idx = loads[k].prf;
            dispatch[k].sq_tail = loads[k].tail;
        end
        next_cycle();
        check("lq_num_free", 32'(lq_num_free), 32'(core_pkg::lq_size - n_loads));
        for (int k = 0; k < n_loads; k++) begin
            alu[k].valid = 1'b1;
            alu[k].is_ls = 1'b1;
            alu[k].rob_idx = loads[k].rob;
            alu[k].addr = loads[k].addr;
        end
        if (kind == 0) begin
            next_cycle();
            except = 1'b1;
            reads_barred = 1'b1;
            bcast_barred = 1'b1;
            for (int c = 0; c < 12; c++) begin
                next_cycle();
                check("lq_num_free", 32'(lq_num_free), 32'(core_pkg::lq_size));
            end
            reads_barred = 1'b0;
            bcast_barred = 1'b0;
        end else begin
            if (kind == 2) begin
                // held behind the store with no address
                reads_barred = 1'b1;
                for (int c = 0; c < 20; c++) begin
                    next_cycle();
                end
                reads_barred = 1'b0;
                stores[blk_slot].addr_valid = 1'b1;
                stores[blk_slot].addr = late_addr;
            end
            waited = 0;
            while (seen != want && waited < wait_limit) begin
                next_cycle();
                waited++;
            end
            if (seen != want) begin
                $display("timeout after %0d cycles, %0d of %0d loads broadcast",
                    waited, $countones(seen), n_loads);
                errors++;
            end
            next_cycle();
            check("lq_num_free", 32'(lq_num_free), 32'(core_pkg::lq_size));
        end
        for (int j = 0; j < core_pkg::lq_size; j++) begin
            stores[j] = '0;
        end
        report($sformatf("test %0d kind %0d", tests_run, kind), start_errors);
    endtask

    initial begin
        int fd;
        int got;
        int need;
        int start_errors;
        string line;
        string rest;
        logic [31:0] fld [9];

        void'($urandom(27918));
        reset = 1'b1;
        except = 1'b0;
        sq_head = '0;
        dc_hit = 1'b0;
        dc_data = '0;
        fill = '0;
        for (int w = 0; w < core_pkg::ways; w++) begin
            dispatch[w] = '0;
            alu[w] = '0;
        end
        for (int j = 0; j < core_pkg::lq_size; j++) begin
            stores[j] = '0;
        end
        seen = '0;
        pend = '0;
        n_loads = 0;
        kind = 0;
        blk_slot = 0;
        late_addr = '0;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        for (int c = 0; c < 16; c++) begin
            @(negedge clock);
        end
        reset = 1'b0;

        // empty queue straight out of reset
        start_errors = errors;
        reads_barred = 1'b1;
        bcast_barred = 1'b1;
        for (int c = 0; c < 4; c++) begin
            next_cycle();
            check("lq_num_free", 32'(lq_num_free), 32'(core_pkg::lq_size));
        end
        reads_barred = 1'b0;
        bcast_barred = 1'b0;
        report("reset", start_errors);

        fd = $fopen("verification/lq_stimulus.txt", "r");
        if (fd == 0) begin
            $display("stimulus file could not be opened");
            errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                rest = line.substr(1, line.len() - 1);
                need = 0;
                got = 0;
                case (line.getc(0))
                    "t": begin
                        need = 2;
                        got = $sscanf(rest, "%h %h", fld[0], fld[1]);
                        kind = int'(fld[0]);
                        sq_head = core_pkg::lq_idx_t'(fld[1]);
                        n_loads = 0;
                    end
                    "s": begin
                        need = 8;
                        got = $sscanf(rest, "%h %h %h %h %h %h %h %h", fld[0], fld[1],
                            fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]);
                        blk_slot = int'(fld[0]) % core_pkg::lq_size;
                        stores[blk_slot].valid = fld[1][0];
                        stores[blk_slot].addr_valid = fld[2][0];
                        stores[blk_slot].data_valid = fld[3][0];
                        stores[blk_slot].size = fld[4][1:0];
                        stores[blk_slot].addr = fld[5][15:0];
                        stores[blk_slot].data = fld[6];
                        late_addr = fld[7][15:0];
                    end
                    "l": begin
                        need = 9;
                        got = $sscanf(rest, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1],
                            fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
                        if (n_loads >= max_loads) begin
                            $display("more loads in one test than dispatch ways");
                            errors++;
                        end else begin
                            loads[n_loads].size = fld[0][1:0];
                            loads[n_loads].is_signed = fld[1][0];
                            loads[n_loads].rob = core_pkg::rob_idx_t'(fld[2]);
                            loads[n_loads].prf = core_pkg::prf_idx_t'(fld[3]);
                            loads[n_loads].tail = core_pkg::lq_idx_t'(fld[4]);
                            loads[n_loads].addr = fld[5][15:0];
                            loads[n_loads].mode = fld[6][1:0];
                            loads[n_loads].mem_data = fld[7];
                            loads[n_loads].exp_data = fld[8];
                            n_loads++;
                        end
                    end
                    "r": begin
                        run_test();
                    end
                    default: begin
                        need = -1;
                    end
                endcase
                if (got != need) begin
                    $display("malformed stimulus line: %s", line);
                    errors++;
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, with errors %0d, check errors %0d",
            tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/lq_stimulus.txt
# t kind sq_head (kind 0 flush, 1 loads, 2 loads held 20 cycles behind a store)
# s slot valid addr_valid data_valid size addr data late_addr
# l size signed rob prf tail addr mode mem_data exp_data (mode 0 miss, 1 hit, 2 forward)
# r runs the test; all fields hex, size 0 byte, 1 half, 2 word
t 0 0
l 2 0 01 01 0 1000 1 12345678 12345678
l 0 1 02 02 0 1008 1 00000080 ffffff80
r
t 1 0
l 0 1 03 11 0 2004 1 555555f3 fffffff3
r
t 1 0
l 1 0 04 12 0 2010 1 1234c3a5 0000c3a5
r
t 1 0
l 2 0 05 13 0 3000 0 deadbeef deadbeef
r
t 1 0
l 1 1 06 14 0 3102 0 77779abc ffff9abc
r
t 1 0
s 2 1 1 1 0 4005 123456a5 0000
l 0 1 07 15 3 4005 2 00000000 ffffffa5
r
t 2 0
s 1 1 0 1 2 0000 11111111 6000
l 2 0 08 16 2 5004 1 cafef00d cafef00d
r
t 1 0
l 0 0 09 20 0 7001 1 ffffff99 00000099
l 2 0 0a 21 0 7100 0 01020304 01020304
r

// File: sources.f
design/core_pkg.sv
design/mem_pkg.sv
design/rr_arbiter.sv
design/lq_alloc.sv
design/lq_store_check.sv
design/lq_entry_array.sv
design/lq_writeback.sv
design/load_queue.sv
verification/load_queue_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = load_queue_tb
FILELIST = sources.f
OBJDIR = obj_dir
PASS_MSG = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
